// File: sim.f
+incdir+src
src/vgaPkg.sv
src/glyphPkg.sv
src/tileFetchIf.sv
src/shadeIf.sv
src/tileAddrGen.sv
src/wbReadPort.sv
src/glyphShader.sv
src/renderCtrl.sv
src/tileRenderTop.sv
verif/tileRender_asserts.sv
verif/tileRenderTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tileRenderTb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
JOBS ?= 4
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tileRenderTb.sv
/* Tile renderer testbench
   Random map memory on Wishbone, a stalling pixel sink and a reference model of the glyph colours */
`timescale 1ns/10ps

module tileRenderTb import vgaPkg::*, glyphPkg::*;;

	`undef GLYPH_TABLE_SVH	// Guard was set by the shader's copy
	`include "glyphTable.svh"

	localparam logic [31:0] Seed = 32'h1baebced;
	localparam int ClkPeriod = 4;
	localparam int CodePix = 41 * 16;	// Codes 0 to 40 at every in-tile position
	localparam int TotalPix = 2 * 640 + CodePix + 64 + 600;
	localparam int WatchdogNs = (16 + 40 * TotalPix) * ClkPeriod;

	typedef struct packed {
		rgbT rgb;
		wbAdrT adr;
	} expT;

	logic clk, rst;
	logic pixValid, pixReady, bright;
	coordT hCount, vCount;
	logic wbCyc, wbStb, wbAck;
	wbAdrT wbAdr;
	wbDatT wbDatI;
	logic outValid, outReady;
	logic [7:0] outR, outG, outB;

	wbDatT mem [65536];	// Video memory seen by the bus model
	expT expQ[$];	// Expected results in request order
	wbAdrT adrQ[$];	// Expected map reads
	logic [31:0] stimRng, busRng, sinkRng;
	bit passed;
	bit failed;

	tileRenderTop #(
		.MapBase(DefMapBase),
		.MapCols(DefMapCols)
	) dut_i (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// Word address of the tile that holds a pixel
	function automatic wbAdrT mapAddr(input coordT h, input coordT v);
		return wbAdrT'(DefMapBase + int'(h) / TileSize + (int'(v) / TileSize) * DefMapCols);
	endfunction

	function automatic expT refPixel(input logic br, input coordT h, input coordT v);
		expT e;
		glyphEntryT g;
		int code;
		int pos;
		e.adr = mapAddr(h, v);
		e.rgb = Palette[PalBlack];	// Blank or unknown code
		code = int'(mem[e.adr][7:0]);
		pos = (int'(v) % TileSize) * TileSize + int'(h) % TileSize;
		if (br && code < GlyphCount) begin
			g = GlyphTable[code];
			e.rgb = Palette[g.mask[pos] ? g.fg : g.bg];
		end
		return e;
	endfunction

	task automatic reportFailure(input string what);
		failed = 1'b1;
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic checkValue(input string sig, input int got, input int want);
		assert (got == want)
		else reportFailure($sformatf("Mismatch at %0t: %s got 0x%0h expected 0x%0h",
			$time, sig, got, want));
	endtask

	// Called at a rising edge, returns at the accept edge
	task automatic sendPixel(input logic br, input coordT h, input coordT v);
		expT e;
		e = refPixel(br, h, v);
		#1;
		pixValid = 1'b1;
		bright = br;
		hCount = h;
		vCount = v;
		do
			@(posedge clk);
		while (!pixReady);
		expQ.push_back(e);
		if (br)
			adrQ.push_back(e.adr);
	endtask

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		pixValid = 1'b0;
		bright = 1'b0;
		hCount = '0;
		vCount = '0;
		stimRng = Seed;
		for (int a = 0; a < 65536; a++) begin
			stimRng = xorshift(stimRng);
			mem[a] = wbDatT'(stimRng % 41);	// Random codes 0 to 40
		end
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;
		@(posedge clk);
		// Bottom row pair of the screen
		for (int v = 478; v < 480; v++)
			for (int h = 0; h < 640; h++)
				sendPixel(1'b1, coordT'(h), coordT'(v));
		// Each code on its own tile in map row 2
		for (int c = 0; c < 41; c++) begin
			mem[mapAddr(coordT'(4 * c), coordT'(8))] = wbDatT'(c);
			for (int p = 0; p < 16; p++)
				sendPixel(1'b1, coordT'(4 * c + p % 4), coordT'(8 + p / 4));
		end
		repeat (64) begin
			stimRng = xorshift(stimRng);
			sendPixel(1'b0, coordT'(stimRng[15:0] % 640), coordT'(stimRng[31:16] % 480));
		end
		repeat (600) begin	// One in eight blank
			stimRng = xorshift(stimRng);
			sendPixel(stimRng[31:29] != 3'd0, coordT'(stimRng[15:0] % 640),
				coordT'(stimRng[28:16] % 480));
		end
		#1 pixValid = 1'b0;
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (8) @(posedge clk);
		assert (adrQ.size() == 0)
		else reportFailure("Error: a visible pixel finished without its map read");
		passed = 1'b1;
		$display("=== PASS ===");
		$finish;
	end

	// Wishbone memory with 0 to 3 cycles of extra ack delay
	initial begin
		wbAck = 1'b0;
		wbDatI = '0;
		busRng = xorshift(Seed);
		forever begin
			@(posedge clk);
			if (wbCyc) begin
				checkValue("wbStb", int'(wbStb), 1);
				assert (adrQ.size() > 0)
				else reportFailure($sformatf("Error at %0t: bus read without a visible pixel",
					$time));
				checkValue("wbAdr", int'(wbAdr), int'(adrQ.pop_front()));
				busRng = xorshift(busRng);
				repeat (busRng % 4) @(posedge clk);
				#1;
				wbAck = 1'b1;
				wbDatI = mem[wbAdr];
				@(posedge clk);	// Ack edge
				#1;
				wbAck = 1'b0;
				wbDatI = '0;
			end
		end
	end

	// Pixel sink and result checker
	initial begin
		expT e;
		outReady = 1'b0;
		sinkRng = xorshift(xorshift(Seed));
		forever begin
			@(posedge clk);
			if (outValid && outReady) begin
				assert (expQ.size() > 0)
				else reportFailure($sformatf("Error at %0t: result with no pixel pending", $time));
				e = expQ.pop_front();
				checkValue("outR", int'(outR), int'(e.rgb.r));
				checkValue("outG", int'(outG), int'(e.rgb.g));
				checkValue("outB", int'(outB), int'(e.rgb.b));
			end
			#1;
			sinkRng = xorshift(sinkRng);
			outReady = sinkRng[1:0] != 2'b00;	// Stall about one cycle in four
		end
	end

	initial begin
		#(WatchdogNs);
		reportFailure($sformatf("Timeout: run did not finish within %0d ns", WatchdogNs));
	end

	final begin
		if (!passed && !failed)
			$display("=== FAIL ===");
	end

endmodule

// File: verif/tileRender_asserts.sv
/* Handshake hold checks for the Wishbone read port and the shader output */
`timescale 1ns/10ps

module tileRenderAsserts #(
	parameter int W = 16,
	parameter bit HasFrame = 1'b1	// Only the bus wraps its strobe in a cycle
) (
	input logic clk,
	input logic rst,
	input logic frame,	// Bus cycle
	input logic valid,
	input logic ready,
	input logic [W-1:0] hold
);

	if (HasFrame) begin : frameChk
		validInFrame: assert property (@(posedge clk) disable iff (rst) valid |-> frame)
			else $error("strobe raised outside its bus cycle");
	end

	// Held until the other side takes it
	validHeld: assert property (@(posedge clk) disable iff (rst) valid && !ready |=> valid)
		else $error("valid dropped before ready");

	holdStable: assert property (@(posedge clk) disable iff (rst)
		valid && !ready |=> $stable(hold))
		else $error("held value changed before ready");

endmodule

bind wbReadPort tileRenderAsserts #(.W(16), .HasFrame(1'b1)) busChk_i (
	.clk(clk),
	.rst(rst),
	.frame(wbCyc),
	.valid(wbStb),
	.ready(wbAck),
	.hold(wbAdr)
);

bind glyphShader tileRenderAsserts #(.W(24), .HasFrame(1'b0)) outChk_i (
	.clk(clk),
	.rst(rst),
	.frame(1'b0),
	.valid(outValid),
	.ready(outReady),
	.hold({outR, outG, outB})
);

// File: src/tileRenderTop.sv
/* Tile renderer top level
   Pixel request in, Wishbone map read out, shaded 24-bit pixel result out */
`timescale 1ns/10ps

module tileRenderTop import vgaPkg::*; #(
	parameter int MapBase = DefMapBase,
	parameter int MapCols = DefMapCols
) (
	input logic clk,
	input logic rst,
	input logic pixValid,
	output logic pixReady,
	input logic bright,
	input coordT hCount,
	input coordT vCount,
	output logic wbCyc,
	output logic wbStb,
	output wbAdrT wbAdr,
	input wbDatT wbDatI,
	input logic wbAck,
	output logic outValid,
	input logic outReady,
	output logic [7:0] outR,
	output logic [7:0] outG,
	output logic [7:0] outB
);

	tileFetchIf fetchBus ();
	shadeIf shadeBus ();

	logic capture;
	wbAdrT tileAdr;
	logic [PixPosW-1:0] tilePixPos;

	// Address generator outputs feed both links
	assign fetchBus.adr = tileAdr;
	assign shadeBus.pixPos = tilePixPos;

	renderCtrl ctrl_i (
		.clk(clk),
		.rst(rst),
		.pixValid(pixValid),
		.bright(bright),
		.pixReady(pixReady),
		.capture(capture),
		.fetch(fetchBus.ctrl),
		.shade(shadeBus.ctrl)
	);

	tileAddrGen #(
		.MapBase(MapBase),
		.MapCols(MapCols)
	) addrGen_i (
		.clk(clk),
		.capture(capture),
		.hCount(hCount),
		.vCount(vCount),
		.adr(tileAdr),
		.pixPos(tilePixPos)
	);

	wbReadPort wbPort_i (
		.clk(clk),
		.rst(rst),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAdr(wbAdr),
		.fetch(fetchBus.port)
	);

	glyphShader shader_i (
		.clk(clk),
		.rst(rst),
		.outReady(outReady),
		.outValid(outValid),
		.outR(outR),
		.outG(outG),
		.outB(outB),
		.shade(shadeBus.shader)
	);

endmodule

// File: src/renderCtrl.sv
/* Render controller
   Accepts one pixel at a time, fetches its tile code and hands it to the shader */
`timescale 1ns/10ps

module renderCtrl import glyphPkg::*; (
	input logic clk,
	input logic rst,
	input logic pixValid,
	input logic bright,
	output logic pixReady,
	output logic capture,
	tileFetchIf.ctrl fetch,
	shadeIf.ctrl shade
);

	typedef enum logic [1:0] {
		Idle,
		Fetch,	// Waiting for the map word
		WaitShade	// Pixel ready, shader still busy
	} stateT;

	stateT state;
	stateT nextState;
	logic blankReg;

	assign capture = pixValid & pixReady;
	assign shade.blank = blankReg;
	assign shade.glyph = glyphT'(fetch.data[7:0]);	// Low byte carries the code
	assign shade.load = ~shade.full & ((state == Fetch && fetch.done) || state == WaitShade);

	always_comb begin
		nextState = state;
		case (state)
			Idle:
				if (capture)
					nextState = bright ? Fetch : WaitShade;
			Fetch:
				if (fetch.done)
					nextState = shade.full ? WaitShade : Idle;
			WaitShade:
				if (!shade.full)
					nextState = Idle;
			default:
				nextState = Idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
			pixReady <= 1'b0;
			fetch.start <= 1'b0;
		end else begin
			state <= nextState;
			pixReady <= nextState == Idle;
			fetch.start <= capture & bright;	// Blank pixels skip the bus
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			blankReg <= ~bright;
	end

endmodule

// File: src/glyphShader.sv
/* Glyph shader
   Picks the pattern colour of one tile pixel and holds it until the sink takes it */
`timescale 1ns/10ps

module glyphShader import glyphPkg::*; (
	input logic clk,
	input logic rst,
	input logic outReady,
	output logic outValid,
	output logic [7:0] outR,
	output logic [7:0] outG,
	output logic [7:0] outB,
	shadeIf.shader shade
);

	`include "glyphTable.svh"

	localparam int GlyphIdxW = $clog2(GlyphCount);

	glyphEntryT entry;
	palIdxT palSel;
	rgbT colour;
	logic known;

	always_comb begin
		known = shade.glyph < GlyphCount;
		entry = GlyphTable[0];
		if (known)
			entry = GlyphTable[shade.glyph[GlyphIdxW-1:0]];
		palSel = entry.mask[shade.pixPos] ? entry.fg : entry.bg;
		if (shade.blank || !known)
			palSel = PalBlack;	// Blanking and unknown codes
		colour = Palette[palSel];
	end

	// Free once the held pixel leaves this cycle
	assign shade.full = outValid & ~outReady;

	always_ff @(posedge clk) begin
		if (rst)
			outValid <= 1'b0;
		else if (shade.load)
			outValid <= 1'b1;
		else if (outReady)
			outValid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (shade.load) begin
			outR <= colour.r;
			outG <= colour.g;
			outB <= colour.b;
		end
	end

endmodule

// File: src/wbReadPort.sv
/* Wishbone classic read master
   One single read per fetch request, returns the map word with a done pulse */
`timescale 1ns/10ps

module wbReadPort import vgaPkg::*; (
	input logic clk,
	input logic rst,
	input wbDatT wbDatI,
	input logic wbAck,
	output logic wbCyc,
	output logic wbStb,
	output wbAdrT wbAdr,
	tileFetchIf.port fetch
);

	logic ackSeen;

	assign ackSeen = wbCyc & wbAck;

	always_ff @(posedge clk) begin
		if (rst) begin
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			fetch.done <= 1'b0;
		end else begin
			fetch.done <= ackSeen;	// Data is registered on the same edge
			if (fetch.start) begin
				wbCyc <= 1'b1;
				wbStb <= 1'b1;
			end else if (ackSeen) begin
				wbCyc <= 1'b0;
				wbStb <= 1'b0;
			end
		end
	end

	// Address held for the whole cycle, word kept until the next read
	always_ff @(posedge clk) begin
		if (fetch.start)
			wbAdr <= fetch.adr;
		if (ackSeen)
			fetch.data <= wbDatI;
	end

endmodule

// File: src/tileAddrGen.sv
/* Tile address generator
   Holds the accepted pixel and forms its glyph map address and in-tile index */
`timescale 1ns/10ps

module tileAddrGen import vgaPkg::*; #(
	parameter int MapBase = DefMapBase,
	parameter int MapCols = DefMapCols
) (
	input logic clk,
	input logic capture,
	input coordT hCount,
	input coordT vCount,
	output wbAdrT adr,
	output logic [PixPosW-1:0] pixPos
);

	localparam int TileShift = $clog2(TileSize);

	coordT hReg;
	coordT vReg;
	coordT tileCol;
	coordT tileRow;

	always_ff @(posedge clk) begin
		if (capture) begin
			hReg <= hCount;
			vReg <= vCount;
		end
	end

	assign tileCol = hReg >> TileShift;
	assign tileRow = vReg >> TileShift;

	// Base + column + row * map width, wraps at 16 bits like the memory bus
	assign adr = wbAdrT'(MapBase) + tileCol + wbAdrT'(tileRow * MapCols);

	// Row in tile times TileSize plus column in tile
	assign pixPos = {vReg[TileShift-1:0], hReg[TileShift-1:0]};

endmodule

// File: src/shadeIf.sv
/* Shade link between the render controller and the glyph shader */
`timescale 1ns/10ps

interface shadeIf import vgaPkg::*, glyphPkg::*; ();

	logic load;
	glyphT glyph;
	logic blank;	// Pixel outside the visible area
	logic [PixPosW-1:0] pixPos;	// From the address generator
	logic full;	// Output register cannot take a pixel

	modport ctrl (
		output load,
		output glyph,
		output blank,
		input full
	);

	modport shader (
		input load,
		input glyph,
		input blank,
		input pixPos,
		output full
	);

endinterface

// File: src/tileFetchIf.sv
/* Tile fetch link between the render controller and the Wishbone read port */
`timescale 1ns/10ps

interface tileFetchIf import vgaPkg::*; ();

	logic start;	// One-cycle fetch request
	wbAdrT adr;	// From the address generator
	logic done;	// One cycle, data valid
	wbDatT data;

	modport ctrl (
		output start,
		input done,
		input data
	);

	modport port (
		input start,
		input adr,
		output done,
		output data
	);

endinterface

// File: src/glyphPkg.sv
/* Glyph codes, palette indices and the RGB palette for the light-cycle display */
package glyphPkg;

	typedef logic [7:0] glyphT;
	typedef logic [2:0] palIdxT;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgbT;

	// Solid squares
	localparam glyphT GlyphBlack = 8'd0;
	localparam glyphT GlyphBlue = 8'd1;
	localparam glyphT GlyphYellow = 8'd2;

	// Blue trail pieces
	localparam glyphT GlyphPathH = 8'd3;
	localparam glyphT GlyphPathV = 8'd4;
	localparam glyphT GlyphCorner = 8'd5;
	localparam glyphT GlyphCornerLD = 8'd6;
	localparam glyphT GlyphCornerLU = 8'd7;
	localparam glyphT GlyphCornerRD = 8'd8;
	localparam glyphT GlyphCornerRU = 8'd9;

	// Blue bike, 3x3 tiles, horizontal
	localparam glyphT GlyphBikeH1 = 8'd10;
	localparam glyphT GlyphBikeH2 = 8'd11;
	localparam glyphT GlyphBikeH3 = 8'd12;
	localparam glyphT GlyphBikeH4 = 8'd13;
	localparam glyphT GlyphBikeH5 = 8'd14;
	localparam glyphT GlyphBikeH6 = 8'd15;
	localparam glyphT GlyphBikeH7 = 8'd16;
	localparam glyphT GlyphBikeH8 = 8'd17;
	localparam glyphT GlyphBikeH9 = 8'd18;

	// Blue bike, vertical
	localparam glyphT GlyphBikeV1 = 8'd19;
	localparam glyphT GlyphBikeV2 = 8'd20;
	localparam glyphT GlyphBikeV3 = 8'd21;
	localparam glyphT GlyphBikeV4 = 8'd22;
	localparam glyphT GlyphBikeV5 = 8'd23;
	localparam glyphT GlyphBikeV6 = 8'd24;
	localparam glyphT GlyphBikeV7 = 8'd25;
	localparam glyphT GlyphBikeV8 = 8'd26;
	localparam glyphT GlyphBikeV9 = 8'd27;

	localparam int GlyphCount = 28;	// Codes at or above this draw black

	localparam palIdxT PalBlack = 3'd0;
	localparam palIdxT PalBlue = 3'd1;
	localparam palIdxT PalYellow = 3'd2;
	localparam palIdxT PalEdge = 3'd3;	// Trail outline
	localparam palIdxT PalInner = 3'd4;	// Trail body
	localparam palIdxT PalTire = 3'd5;

	localparam rgbT Palette [8] = '{
		'{8'd0, 8'd0, 8'd0},
		'{8'd0, 8'd0, 8'd255},
		'{8'd255, 8'd255, 8'd0},
		'{8'd0, 8'd162, 8'd230},
		'{8'd156, 8'd219, 8'd230},
		'{8'd127, 8'd127, 8'd127},
		'{8'd0, 8'd0, 8'd0},	// Spare entries
		'{8'd0, 8'd0, 8'd0}
	};

endpackage

// File: src/vgaPkg.sv
/* Screen and map geometry for the tile renderer
   with the coordinate and Wishbone word types */
package vgaPkg;

	typedef logic [15:0] coordT;	// Screen coordinate
	typedef logic [15:0] wbAdrT;	// Map word address
	typedef logic [15:0] wbDatT;	// Map word

	// Tiles are square, 4 pixels a side
	localparam int TileSize = 4;

	// In-tile index, row * TileSize + column
	localparam int PixPosW = 4;

	// Default glyph map placement in video memory
	localparam int DefMapBase = 40000;
	localparam int DefMapCols = 160;	// Tiles per map row

endpackage

// File: src/glyphTable.svh
/* Glyph pattern table, one 4x4 mask per code with foreground and background colour
   Mask bit n is in-tile pixel n, a set bit selects the foreground */
`ifndef GLYPH_TABLE_SVH
`define GLYPH_TABLE_SVH

typedef struct packed {
	logic [15:0] mask;
	palIdxT fg;
	palIdxT bg;
} glyphEntryT;

localparam glyphEntryT GlyphTable [GlyphCount] = '{
	GlyphBlack:    '{16'h0000, PalBlack, PalBlack},
	GlyphBlue:     '{16'hFFFF, PalBlue, PalBlack},
	GlyphYellow:   '{16'hFFFF, PalYellow, PalBlack},
	// Trail pieces, edge drawn as foreground
	GlyphPathH:    '{16'hF00F, PalEdge, PalInner},
	GlyphPathV:    '{16'h9999, PalEdge, PalInner},
	GlyphCorner:   '{16'hF99F, PalEdge, PalInner},
	GlyphCornerLD: '{16'h988F, PalEdge, PalInner},
	GlyphCornerLU: '{16'hF889, PalEdge, PalInner},
	GlyphCornerRD: '{16'h911F, PalEdge, PalInner},
	GlyphCornerRU: '{16'hF119, PalEdge, PalInner},
	// Bike body is foreground, tires or empty space behind it
	GlyphBikeH1:   '{16'hEE00, PalBlue, PalBlack},
	GlyphBikeH2:   '{16'hFF00, PalBlue, PalBlack},
	GlyphBikeH3:   '{16'h7700, PalBlue, PalBlack},
	GlyphBikeH4:   '{16'h8888, PalBlue, PalTire},
	GlyphBikeH5:   '{16'hF00F, PalBlue, PalTire},
	GlyphBikeH6:   '{16'h1111, PalBlue, PalTire},
	GlyphBikeH7:   '{16'h00EE, PalBlue, PalBlack},
	GlyphBikeH8:   '{16'h00FF, PalBlue, PalBlack},
	GlyphBikeH9:   '{16'h0077, PalBlue, PalBlack},
	GlyphBikeV1:   '{16'hCCC0, PalBlue, PalBlack},
	GlyphBikeV2:   '{16'hF000, PalBlue, PalTire},
	GlyphBikeV3:   '{16'h3330, PalBlue, PalBlack},
	GlyphBikeV4:   '{16'hCCCC, PalBlue, PalBlack},
	GlyphBikeV5:   '{16'h9999, PalBlue, PalTire},
	GlyphBikeV6:   '{16'h3333, PalBlue, PalBlack},
	GlyphBikeV7:   '{16'h0CCC, PalBlue, PalBlack},
	GlyphBikeV8:   '{16'h000F, PalBlue, PalTire},
	GlyphBikeV9:   '{16'h0333, PalBlue, PalBlack}
};

`endif
